//--- rtl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Fetch path sizing
//////////////////////////////////////////////////////////////////////

// Data and address width of the instruction port
`define FETCH_XLEN 32

// Instruction ROM depth in words
`define FETCH_ROM_WORDS 64

// Cycles from grant to rvalid in the ROM
`define FETCH_ROM_LAT 2

// Requests the fetch controller may keep in flight
// Also the depth of the response buffer toward ID
`define FETCH_MAX_OUTSTANDING 2

`endif

//--- rtl/core_pkg.sv
`include "fetch_consts.svh"

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    // Byte address on the instruction port
    typedef logic [`FETCH_XLEN-1:0] addr_t;
    // Raw instruction word
    typedef logic [`FETCH_XLEN-1:0] word_t;
    // Boot address in words, shifted left by 2 at reset
    typedef logic [`FETCH_XLEN-3:0] boot_t;
    // Byte enables of one bus word
    typedef logic [`FETCH_XLEN/8-1:0] be_t;
    // Requests in flight, buffered words, stale responses
    typedef logic [$clog2(`FETCH_MAX_OUTSTANDING+1)-1:0] cnt_t;

    // Target kind carried by an ID or EX instruction
    typedef enum logic [1:0] {
        PC_SEQ,
        PC_JUMP,
        PC_BRANCH
    } pc_source_t;

    // Fetch controller states
    typedef enum logic [1:0] {
        FS_IDLE,
        FS_RUN,
        FS_FLUSH    // Flushed while a request still waits for grant
    } fetch_state_t;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    // Word handed to decode
    typedef struct packed {
        addr_t pc;
        word_t instr;
    } if_id_t;

    // Everything that can move the pc away from pc + 4
    typedef struct packed {
        logic       valid_id;
        logic       valid_ex;
        logic       trap_id;
        logic       trap_ex;
        logic       is_mret;
        pc_source_t pc_source_id;
        pc_source_t pc_source_ex;
        addr_t      jump_target_id;
        addr_t      branch_target_ex;
        addr_t      mtvec;
        addr_t      mepc;
        logic       branch_decision_ex;
    } redirect_t;

    // OBI A channel, master to slave
    typedef struct packed {
        logic  req;
        addr_t addr;
        logic  we;
        be_t   be;
        word_t wdata;
    } obi_req_t;

    // OBI grant and R channel, slave to master
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } obi_rsp_t;

endpackage

//--- rtl/pc_controller.sv
`timescale 1ns/1ps

module pc_controller (
    input  core_pkg::addr_t     fetch_pc_i,
    input  core_pkg::redirect_t redirect_i,
    output core_pkg::addr_t     next_pc_o,
    output logic                redirect_o
);
    import core_pkg::*;

    logic branch_taken;
    logic jump_id;

    // Taken branch resolved in EX
    assign branch_taken = redirect_i.valid_ex
                          && (redirect_i.pc_source_ex == PC_BRANCH)
                          && redirect_i.branch_decision_ex;

    // Jump resolved in ID
    assign jump_id = redirect_i.valid_id && (redirect_i.pc_source_id == PC_JUMP);

    //////////////////////////////////////////////////////////////////////
    // Next pc by fixed priority
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        redirect_o = 1'b1;
        if (redirect_i.trap_ex) begin
            // Oldest instruction traps, everything younger is gone
            next_pc_o = redirect_i.mtvec;
        end else if (branch_taken) begin
            next_pc_o = redirect_i.branch_target_ex;
        end else if (redirect_i.trap_id) begin
            next_pc_o = redirect_i.mtvec;
        end else if (redirect_i.is_mret) begin
            // Return from handler
            next_pc_o = redirect_i.mepc;
        end else if (jump_id) begin
            next_pc_o = redirect_i.jump_target_id;
        end else begin
            // Plain sequential fetch, no flush
            next_pc_o  = fetch_pc_i + addr_t'(4);
            redirect_o = 1'b0;
        end
    end

    // No compressed support, so ID, EX and the CSRs must hand over word targets
    always_comb begin
        if (!$isunknown(next_pc_o)) begin
            assert (next_pc_o[1:0] == 2'b00)
                else $error("pc_controller: next pc %h not word aligned", next_pc_o);
        end
    end

endmodule

//--- rtl/obi_fetch_controller.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module obi_fetch_controller (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  core_pkg::addr_t    fetch_pc_i,
    input  logic               flush_i,
    output logic               issued_o,
    output core_pkg::obi_req_t obi_req_o,
    input  core_pkg::obi_rsp_t obi_rsp_i,
    output core_pkg::if_id_t   fetch_o,
    output logic               valid_o,
    input  logic               stall_i
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(`FETCH_MAX_OUTSTANDING);
    localparam int USE_W = $bits(cnt_t) + 1;

    fetch_state_t     state_q, state_d;
    cnt_t             outst_q, outst_d;
    cnt_t             kill_q, kill_d;
    cnt_t             buf_cnt_q;
    logic [PTR_W-1:0] pc_wr_q, pc_rd_q;
    logic [PTR_W-1:0] buf_wr_q, buf_rd_q;
    addr_t            pc_fifo_q [`FETCH_MAX_OUTSTANDING];
    if_id_t           buf_q [`FETCH_MAX_OUTSTANDING];
    if_id_t           rsp_word;
    logic [USE_W-1:0] in_use;
    logic             grant, drop, keep, bypass, take, push, pop;

    // Slots still taken after this cycle's hand-over to ID
    assign in_use = USE_W'(outst_q) + USE_W'(buf_cnt_q) - USE_W'(take);

    // Instruction reads only
    assign obi_req_o.req   = (state_q != FS_IDLE) && (in_use < USE_W'(`FETCH_MAX_OUTSTANDING));
    assign obi_req_o.addr  = fetch_pc_i;
    assign obi_req_o.we    = 1'b0;
    assign obi_req_o.be    = '1;
    assign obi_req_o.wdata = '0;

    assign grant    = obi_req_o.req && obi_rsp_i.gnt;
    assign issued_o = grant;
    assign drop     = obi_rsp_i.rvalid && (kill_q != '0);
    assign keep     = obi_rsp_i.rvalid && (kill_q == '0);

    // Pair rdata with the pc of the oldest request
    assign rsp_word.pc    = pc_fifo_q[pc_rd_q];
    assign rsp_word.instr = obi_rsp_i.rdata;

    // Empty buffer passes the response straight through
    assign bypass  = (buf_cnt_q == '0);
    assign fetch_o = bypass ? rsp_word : buf_q[buf_rd_q];
    // A redirect this cycle makes any word here stale
    assign valid_o = ((buf_cnt_q != '0) || keep) && !flush_i;
    assign take    = valid_o && !stall_i;
    assign push    = keep && !flush_i && !(bypass && take);
    assign pop     = take && !bypass;

    assign outst_d = outst_q + cnt_t'(grant) - cnt_t'(obi_rsp_i.rvalid);

    always_comb begin
        kill_d = kill_q - cnt_t'(drop);
        // Request that was pending at the flush is stale when it goes out
        if ((state_q == FS_FLUSH) && grant) begin
            kill_d = kill_d + cnt_t'(1);
        end
        // Everything in flight after this edge belongs to the old path
        if (flush_i) begin
            kill_d = outst_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            FS_IDLE:  state_d = FS_RUN;
            FS_RUN:   if (flush_i && obi_req_o.req && !obi_rsp_i.gnt) state_d = FS_FLUSH;
            FS_FLUSH: if (grant) state_d = FS_RUN;
            default:  state_d = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= FS_IDLE;
            outst_q   <= '0;
            kill_q    <= '0;
            buf_cnt_q <= '0;
            pc_wr_q   <= '0;
            pc_rd_q   <= '0;
            buf_wr_q  <= '0;
            buf_rd_q  <= '0;
        end else begin
            state_q <= state_d;
            outst_q <= outst_d;
            kill_q  <= kill_d;
            if (grant) pc_wr_q <= pc_wr_q + 1'b1;
            // Every rvalid retires one pc, dropped or not
            if (obi_rsp_i.rvalid) pc_rd_q <= pc_rd_q + 1'b1;
            if (flush_i) begin
                buf_cnt_q <= '0;
                buf_rd_q  <= buf_wr_q;
            end else begin
                if (push) buf_wr_q <= buf_wr_q + 1'b1;
                if (pop) buf_rd_q <= buf_rd_q + 1'b1;
                buf_cnt_q <= buf_cnt_q + cnt_t'(push) - cnt_t'(pop);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) pc_fifo_q[pc_wr_q] <= fetch_pc_i;
        if (push) buf_q[buf_wr_q] <= rsp_word;
    end

    // OBI master rules, address comes from the pc register in if_stage
    a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_o.req && !obi_rsp_i.gnt |=> $stable(obi_req_o.addr));
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_o.req && !obi_rsp_i.gnt |=> obi_req_o.req);
    a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_rsp_i.rvalid |-> (outst_q != '0));

endmodule

//--- rtl/if_stage.sv
`timescale 1ns/1ps

module if_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  core_pkg::boot_t     boot_addr_i,
    input  core_pkg::redirect_t redirect_i,
    input  logic                stall_if_i,
    output core_pkg::obi_req_t  insn_obi_req_o,
    input  core_pkg::obi_rsp_t  insn_obi_rsp_i,
    output core_pkg::if_id_t    fetch_if_o,
    output logic                valid_if_o
);
    import core_pkg::*;

    addr_t fetch_pc_q;
    addr_t next_pc;
    addr_t pending_pc_q;
    logic  pending_q;
    logic  redirect;
    logic  issued;
    logic  waiting;

    pc_controller u_pc_controller (
        .fetch_pc_i ( fetch_pc_q ),
        .redirect_i ( redirect_i ),
        .next_pc_o  ( next_pc    ),
        .redirect_o ( redirect   )
    );

    obi_fetch_controller u_fetch_ctrl (
        .clk_i      ( clk_i          ),
        .rst_n_i    ( rst_n_i        ),
        .fetch_pc_i ( fetch_pc_q     ),
        .flush_i    ( redirect       ),
        .issued_o   ( issued         ),
        .obi_req_o  ( insn_obi_req_o ),
        .obi_rsp_i  ( insn_obi_rsp_i ),
        .fetch_o    ( fetch_if_o     ),
        .valid_o    ( valid_if_o     ),
        .stall_i    ( stall_if_i     )
    );

    // Request on the bus but not granted yet, address must not move
    assign waiting = insn_obi_req_o.req && !insn_obi_rsp_i.gnt;

    //////////////////////////////////////////////////////////////////////
    // Fetch pc
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fetch_pc_q <= {boot_addr_i, 2'b00};
            pending_q  <= 1'b0;
        end else if (redirect) begin
            if (waiting) begin
                // Park the target until the stuck request is granted
                pending_q <= 1'b1;
            end else begin
                fetch_pc_q <= next_pc;
                pending_q  <= 1'b0;
            end
        end else if (issued) begin
            fetch_pc_q <= pending_q ? pending_pc_q : next_pc;
            pending_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (redirect && waiting) pending_pc_q <= next_pc;
    end

    // A parked target only exists while the controller holds its request
    a_pending_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pending_q |-> insn_obi_req_o.req);

endmodule

//--- rtl/insn_rom.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module insn_rom (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  core_pkg::obi_req_t obi_req_i,
    output core_pkg::obi_rsp_t obi_rsp_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(`FETCH_ROM_WORDS);

    word_t                     mem [`FETCH_ROM_WORDS];
    logic [`FETCH_ROM_LAT-1:0] vld_q;
    word_t                     data_q [`FETCH_ROM_LAT];
    logic [IDX_W-1:0]          idx;
    logic                      accept;

    // Instruction image
    initial begin
        $readmemh("rom.hex", mem);
    end

    // Word index, address wraps at the ROM depth
    assign idx = obi_req_i.addr[2 +: IDX_W];

    //////////////////////////////////////////////////////////////////////
    // Grant and latency pipe
    //////////////////////////////////////////////////////////////////////

    // rready is tied high, so the pipe shifts every cycle
    // and its input slot is always free
    assign obi_rsp_o.gnt = 1'b1;
    assign accept        = obi_req_i.req && obi_rsp_o.gnt;

    // Valid bits, stage 0 fills on a granted read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= accept;
            for (int i = 1; i < `FETCH_ROM_LAT; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Read data follows its valid bit
    always_ff @(posedge clk_i) begin
        if (accept) data_q[0] <= mem[idx];
        for (int i = 1; i < `FETCH_ROM_LAT; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    // Last stage drives the R channel
    assign obi_rsp_o.rvalid = vld_q[`FETCH_ROM_LAT-1];
    assign obi_rsp_o.rdata  = data_q[`FETCH_ROM_LAT-1];

    // Read-only slave, the fetch master must never write
    a_read_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_i.req |-> !obi_req_i.we && (obi_req_i.be == '1));

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  core_pkg::boot_t     boot_addr_i,
    input  core_pkg::redirect_t redirect_i,
    input  logic                stall_i,
    output core_pkg::if_id_t    fetch_o,
    output logic                valid_o
);
    import core_pkg::*;

    // OBI instruction port between fetch and ROM
    obi_req_t insn_req;
    obi_rsp_t insn_rsp;

    //////////////////////////////////////////////////////////////////////
    // Fetch stage
    //////////////////////////////////////////////////////////////////////

    if_stage u_if_stage (
        .clk_i          ( clk_i       ),
        .rst_n_i        ( rst_n_i     ),
        .boot_addr_i    ( boot_addr_i ),
        .redirect_i     ( redirect_i  ),
        .stall_if_i     ( stall_i     ),
        .insn_obi_req_o ( insn_req    ),
        .insn_obi_rsp_i ( insn_rsp    ),
        .fetch_if_o     ( fetch_o     ),
        .valid_if_o     ( valid_o     )
    );

    // Instruction memory, fixed read latency
    insn_rom u_insn_rom (
        .clk_i     ( clk_i    ),
        .rst_n_i   ( rst_n_i  ),
        .obi_req_i ( insn_req ),
        .obi_rsp_o ( insn_rsp )
    );

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb;
    import core_pkg::*;

    localparam boot_t BOOT_WORD  = 30'h0000_0005;
    localparam addr_t MTVEC      = 32'h0000_0080;
    localparam addr_t MEPC       = 32'h0000_00c4;
    localparam int    WAIT_LIMIT = 2000;
    localparam int    IDX_W      = $clog2(`FETCH_ROM_WORDS);

    logic      clk = 1'b0;
    logic      rst_n;
    boot_t     boot_addr;
    redirect_t redirect;
    logic      stall;
    if_id_t    fetch;
    logic      valid;

    // Scoreboard state
    word_t  rom_img [`FETCH_ROM_WORDS];
    addr_t  expected_pc;
    int     accepted_cnt;
    int     stall_pct;
    logic   held;
    if_id_t held_word;

    fetch_top u_dut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .boot_addr_i ( boot_addr ),
        .redirect_i  ( redirect  ),
        .stall_i     ( stall     ),
        .fetch_o     ( fetch     ),
        .valid_o     ( valid     )
    );

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Expected word at byte address over 4 wrapping at the ROM depth
    function automatic word_t rom_word(input addr_t a);
        logic [IDX_W-1:0] idx;
        idx = IDX_W'((a >> 2) % `FETCH_ROM_WORDS);
        return rom_img[idx];
    endfunction

    // Any source that leaves the sequential path
    function automatic logic redirect_hit(input redirect_t r);
        return r.trap_ex || r.trap_id || r.is_mret
               || (r.valid_ex && (r.pc_source_ex == PC_BRANCH) && r.branch_decision_ex)
               || (r.valid_id && (r.pc_source_id == PC_JUMP));
    endfunction

    // Target by priority from EX trap down to ID jump
    function automatic addr_t redirect_target(input redirect_t r);
        if (r.trap_ex) return r.mtvec;
        if (r.valid_ex && (r.pc_source_ex == PC_BRANCH) && r.branch_decision_ex) begin
            return r.branch_target_ex;
        end
        if (r.trap_id) return r.mtvec;
        if (r.is_mret) return r.mepc;
        return r.jump_target_id;
    endfunction

    // CSR values present while no redirect is raised
    function automatic redirect_t idle_redirect();
        redirect_t r;
        r       = '0;
        r.mtvec = MTVEC;
        r.mepc  = MEPC;
        return r;
    endfunction

    function automatic redirect_t id_jump(input addr_t target);
        redirect_t r;
        r                = idle_redirect();
        r.valid_id       = 1'b1;
        r.pc_source_id   = PC_JUMP;
        r.jump_target_id = target;
        return r;
    endfunction

    function automatic redirect_t ex_branch(input addr_t target, input logic taken);
        redirect_t r;
        r                    = idle_redirect();
        r.valid_ex           = 1'b1;
        r.pc_source_ex       = PC_BRANCH;
        r.branch_target_ex   = target;
        r.branch_decision_ex = taken;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Compare at the falling edge when inputs and outputs have settled
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("valid_o", 32'(valid), 32'd0);
            check_value("insn_req.req", 32'(u_dut.insn_req.req), 32'd0);
            held = 1'b0;
        end else begin
            // Stalled word must stay on the port unchanged
            if (held && !redirect_hit(redirect)) begin
                check_value("valid_o", 32'(valid), 32'd1);
                check_value("fetch_o.pc", fetch.pc, held_word.pc);
                check_value("fetch_o.instr", fetch.instr, held_word.instr);
            end
            held = 1'b0;
            // Redirect sampled at the next edge discards the old path
            if (redirect_hit(redirect)) begin
                expected_pc = redirect_target(redirect);
            end else if (valid && stall) begin
                held      = 1'b1;
                held_word = fetch;
            end
            // Word taken by ID at the next edge
            if (valid && !stall) begin
                check_value("fetch_o.pc", fetch.pc, expected_pc);
                check_value("fetch_o.instr", fetch.instr, rom_word(expected_pc));
                expected_pc  = expected_pc + 32'd4;
                accepted_cnt = accepted_cnt + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Random back-pressure from ID
    initial begin
        stall = 1'b0;
        void'($urandom(32'h3f5e_0b8f));
        forever begin
            @(posedge clk);
            stall <= (stall_pct > 0) && ($urandom_range(99) < stall_pct);
        end
    end

    task automatic wait_accepted(input int n);
        int target;
        int cycles;
        target = accepted_cnt + n;
        cycles = 0;
        while ((accepted_cnt < target) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        if (accepted_cnt < target) begin
            abort_run($sformatf("Timeout while waiting for %0d accepted words", n));
        end
    endtask

    task automatic drive_redirect(input redirect_t r);
        @(posedge clk);
        redirect <= r;
    endtask

    // One-cycle redirect pulse
    task automatic apply_redirect(input redirect_t r);
        drive_redirect(r);
        drive_redirect(idle_redirect());
    endtask

    task automatic run_redirect_checks();
        redirect_t r;
        apply_redirect(id_jump(32'h0000_0030));
        wait_accepted(6);
        apply_redirect(ex_branch(32'h0000_00a0, 1'b1));
        wait_accepted(6);
        // Not taken so the sequence carries on
        apply_redirect(ex_branch(32'h0000_0010, 1'b0));
        wait_accepted(6);
        // EX trap over taken branch over ID jump
        r                    = id_jump(32'h0000_0040);
        r.valid_ex           = 1'b1;
        r.pc_source_ex       = PC_BRANCH;
        r.branch_target_ex   = 32'h0000_0020;
        r.branch_decision_ex = 1'b1;
        r.trap_ex            = 1'b1;
        apply_redirect(r);
        wait_accepted(6);
        r         = idle_redirect();
        r.is_mret = 1'b1;
        apply_redirect(r);
        wait_accepted(6);
        // trap_id beats mret
        r.trap_id = 1'b1;
        apply_redirect(r);
        wait_accepted(6);
        // Three redirects back to back where only the last path survives
        r.trap_id = 1'b0;
        drive_redirect(ex_branch(32'h0000_0060, 1'b1));
        drive_redirect(r);
        drive_redirect(id_jump(32'h0000_00f0));
        drive_redirect(idle_redirect());
        wait_accepted(8);
    endtask

    initial begin
        rst_n        = 1'b0;
        boot_addr    = BOOT_WORD;
        redirect     = idle_redirect();
        stall_pct    = 0;
        accepted_cnt = 0;
        held         = 1'b0;
        expected_pc  = {BOOT_WORD, 2'b00};
        $readmemh("rom.hex", rom_img);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // Straight-line fetch from boot
        wait_accepted(20);
        stall_pct <= 40;
        wait_accepted(40);
        stall_pct <= 0;
        run_redirect_checks();
        // Same redirects under back-pressure
        stall_pct <= 35;
        run_redirect_checks();
        stall_pct <= 0;
        wait_accepted(4);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- rom.hex
// One 32-bit instruction word per line, word address 0 to 63
1a2b3c03
f0e1d207
00c5800b
7e31a40f
5d2e9013
0b8f3f17
c4a1e61b
33d0771f
9e6b2c23
004a1527
e8f3902b
6c15bd2f
a07e4133
2f9c0837
d35a6e3b
81c7f23f
4e0b9d43
b6f25047
12ad3e4b
f97c614f
0de38a53
a2145c57
57be095b
c8d1f35f
3b6a7263
e40f1867
7193cc6b
08e5b46f
bc2d4173
659af077
d7013e7b
2c8e957f
931fa683
4ab67c87
f5024d8b
1e7d398f
a86cf293
073b1e97
ce95a09b
62f8079f
b14c5da3
3d27e8a7
e06b12ab
8f9a34af
24d1c6b3
c73e0fb7
5b06a9bb
f2e85dbf
0a4f73c3
96b2e1c7
4d7c0acb
e1395fcf
7b04c2d3
28fde6d7
d46a19db
6e81b4df
a5d73ce3
19e2f0e7
fc5b87eb
43a06def
b7c928f3
02f5d1f7
8d3e46fb
e96a7cff

//--- files.f
+incdir+rtl
rtl/core_pkg.sv
rtl/pc_controller.sv
rtl/obi_fetch_controller.sv
rtl/if_stage.sv
rtl/insn_rom.sv
rtl/fetch_top.sv
bench/fetch_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_tb -Mdir obj_dir -o fetch_sim -f files.f \
    && ./obj_dir/fetch_sim \
    && echo "Simulation exited cleanly" \
    || { echo "Build or simulation returned an error"; exit 1; }
